// File: design/sl_pkg.sv
// scanline subsystem package
// shared widths, pipeline latency, register map and profile encodings,
// plus the profile shaping functions used by the emulator

package sl_pkg;

  ////////////////////////////////////////
  // widths and latency
  ////////////////////////////////////////

  localparam int COLOR_W     = 8;           // bits per colour channel
  localparam int VDATA_W     = 3 * COLOR_W; // {red, green, blue}
  localparam int Y_W         = COLOR_W + 1; // luma estimate, g + (r+b)/2
  localparam int PROC_STAGES = 10;          // emulator latency in VCLK cycles

  // positions inside one source line, 8'h100 is a full line
  localparam logic [7:0] SL_POS_HALF    = 8'h80;
  localparam logic [7:0] SL_POS_QUARTER = 8'h40; // normal scanline start
  localparam logic [7:0] SL_WIN_W       = 8'h40; // profile ramp width

  // line multiplier limits and position steps (256/M)
  localparam logic [2:0] SL_MULT_MIN = 3'd2;
  localparam logic [2:0] SL_MULT_MAX = 3'd4;
  localparam logic [7:0] SL_STEP_M2  = 8'd128;
  localparam logic [7:0] SL_STEP_M3  = 8'd85;
  localparam logic [7:0] SL_STEP_M4  = 8'd64;

  ////////////////////////////////////////
  // encodings
  ////////////////////////////////////////

  typedef enum logic [1:0] {
    SL_HANN  = 2'd0,
    SL_GAUSS = 2'd1,
    SL_RECT  = 2'd2,
    SL_FLAT  = 2'd3  // full strength over the upper half of the ramp
  } sl_profile_e;

  typedef enum logic [1:0] {
    SL_REG_CTRL     = 2'd0, // [0] enable, [1] thick, [3:2] profile
    SL_REG_STRENGTH = 2'd1, // [7:0]
    SL_REG_BLOOM    = 2'd2, // [4:0]
    SL_REG_MULT     = 2'd3  // [2:0], clamped to 2..4
  } sl_reg_e;

  ////////////////////////////////////////
  // profile shaping
  ////////////////////////////////////////

  // raised-cosine like ramp, smoothstep t*t*(3-2t) on a 64 step grid
  // 0 at pos 0, 255 at pos 63
  function automatic logic [7:0] hann_shape(input logic [5:0] pos);
    logic [19:0] t;
    logic [19:0] acc;
    t   = 20'(pos);
    acc = t * t * (20'd192 - (t << 1)); // max 261954 at t=63
    return acc[17:10];
  endfunction

  // squared hann, slow start and a narrower core
  function automatic logic [7:0] gauss_shape(input logic [5:0] pos);
    logic [15:0] h;
    logic [15:0] sq;
    h  = 16'(hann_shape(pos));
    sq = h * h + 16'd255; // +255 keeps the top at 255
    return sq[15:8];
  endfunction

endpackage

// File: design/sl_cfg_regs.sv
`timescale 1ns/1ps
// scanline configuration registers
// host writes land in a pending set during vertical blanking only,
// the live set takes the pending values at the end of blanking

module sl_cfg_regs (
  input  logic                VCLK_i,
  input  logic                nVRST_i,
  input  logic                vsync_i,
  input  logic                cfg_valid_i,
  input  sl_pkg::sl_reg_e     cfg_addr_i,
  input  logic [7:0]          cfg_wdata_i,
  output logic                cfg_ready_o,
  output logic                sl_en_o,
  output logic                sl_thickness_o,
  output sl_pkg::sl_profile_e sl_profile_o,
  output logic [7:0]          sl_strength_o,
  output logic [4:0]          sl_bloom_o,
  output logic [2:0]          sl_mult_o
);

  logic                vsync_q;
  logic                vsync_fall_w;
  logic                wr_w;
  logic [2:0]          mult_clamp_w;

  // pending set
  logic                en_p, thick_p;
  sl_pkg::sl_profile_e profile_p;
  logic [7:0]          strength_p;
  logic [4:0]          bloom_p;
  logic [2:0]          mult_p;

  assign cfg_ready_o  = vsync_i;              // accept only in vertical blanking
  assign wr_w         = cfg_valid_i & cfg_ready_o;
  assign vsync_fall_w = vsync_q & ~vsync_i;  // end of blanking

  always_comb begin
    if (cfg_wdata_i < 8'(sl_pkg::SL_MULT_MIN))
      mult_clamp_w = sl_pkg::SL_MULT_MIN;
    else if (cfg_wdata_i > 8'(sl_pkg::SL_MULT_MAX))
      mult_clamp_w = sl_pkg::SL_MULT_MAX;
    else
      mult_clamp_w = cfg_wdata_i[2:0];
  end

  ////////////////////////////////////////
  // write decode into pending set
  ////////////////////////////////////////

  always_ff @(posedge VCLK_i or negedge nVRST_i) begin
    if (!nVRST_i) begin
      vsync_q    <= 1'b0;
      en_p       <= 1'b0;
      thick_p    <= 1'b0;
      profile_p  <= sl_pkg::SL_RECT;
      strength_p <= 8'd0;
      bloom_p    <= 5'd0;
      mult_p     <= sl_pkg::SL_MULT_MIN;
    end else begin
      vsync_q <= vsync_i;
      if (wr_w) begin
        case (cfg_addr_i)
          sl_pkg::SL_REG_CTRL: begin
            en_p      <= cfg_wdata_i[0];
            thick_p   <= cfg_wdata_i[1];
            profile_p <= sl_pkg::sl_profile_e'(cfg_wdata_i[3:2]);
          end
          sl_pkg::SL_REG_STRENGTH: strength_p <= cfg_wdata_i;
          sl_pkg::SL_REG_BLOOM:    bloom_p    <= cfg_wdata_i[4:0];
          default:                 mult_p     <= mult_clamp_w; // SL_REG_MULT
        endcase
      end
    end
  end

  ////////////////////////////////////////
  // live set, frame stable
  ////////////////////////////////////////

  always_ff @(posedge VCLK_i or negedge nVRST_i) begin
    if (!nVRST_i) begin
      sl_en_o        <= 1'b0;
      sl_thickness_o <= 1'b0;
      sl_profile_o   <= sl_pkg::SL_RECT;
      sl_strength_o  <= 8'd0;
      sl_bloom_o     <= 5'd0;
      sl_mult_o      <= sl_pkg::SL_MULT_MIN;
    end else if (vsync_fall_w) begin
      sl_en_o        <= en_p;
      sl_thickness_o <= thick_p;
      sl_profile_o   <= profile_p;
      sl_strength_o  <= strength_p;
      sl_bloom_o     <= bloom_p;
      sl_mult_o      <= mult_p;
    end
  end

endmodule

// File: design/sl_line_phase.sv
`timescale 1ns/1ps
// line phase tracker
// counts output lines modulo the line multiplier and gives each line
// its relative position inside the source line, k*256/M

module sl_line_phase (
  input  logic       VCLK_i,
  input  logic       nVRST_i,
  input  logic       hsync_i,
  input  logic       vsync_i,
  input  logic [2:0] sl_mult_i,
  output logic [7:0] sl_rel_pos_o
);

  logic       hsync_q, vsync_q;
  logic       hsync_rise_w, vsync_rise_w;
  logic [1:0] k_q;          // sub-line counter, 0..M-1
  logic [1:0] k_nxt_w;
  logic [2:0] k_inc_w;
  logic [7:0] step_w;       // 256/M, truncated
  logic [7:0] pos_nxt_w;

  ////////////////////////////////////////
  // sync edge detection
  ////////////////////////////////////////

  always_ff @(posedge VCLK_i or negedge nVRST_i) begin
    if (!nVRST_i) begin
      hsync_q <= 1'b0;
      vsync_q <= 1'b0;
    end else begin
      hsync_q <= hsync_i;
      vsync_q <= vsync_i;
    end
  end

  assign hsync_rise_w = hsync_i & ~hsync_q;
  assign vsync_rise_w = vsync_i & ~vsync_q;

  ////////////////////////////////////////
  // sub-line counter
  ////////////////////////////////////////

  assign k_inc_w = {1'b0, k_q} + 3'd1;

  always_comb begin
    k_nxt_w = k_q;
    if (vsync_rise_w)
      k_nxt_w = 2'd0;                    // new frame starts at sub-line 0
    else if (hsync_rise_w) begin
      if (k_inc_w >= sl_mult_i)
        k_nxt_w = 2'd0;                  // wrap at the multiplier
      else
        k_nxt_w = k_inc_w[1:0];
    end
  end

  // per multiplier step, the cfg block keeps M within 2..4
  always_comb begin
    case (sl_mult_i)
      3'd3:    step_w = sl_pkg::SL_STEP_M3;
      3'd4:    step_w = sl_pkg::SL_STEP_M4;
      default: step_w = sl_pkg::SL_STEP_M2;
    endcase
  end

  assign pos_nxt_w = k_nxt_w * step_w; // at most 3*64 or 2*85, fits 8 bits

  ////////////////////////////////////////
  // registered position
  ////////////////////////////////////////

  // k and the position move together, one cycle after the hsync rise
  always_ff @(posedge VCLK_i or negedge nVRST_i) begin
    if (!nVRST_i) begin
      k_q          <= 2'd0;
      sl_rel_pos_o <= 8'd0;
    end else begin
      k_q          <= k_nxt_w;
      sl_rel_pos_o <= pos_nxt_w; // stays constant across the line
    end
  end

endmodule

// File: design/scanline_emu.sv
`timescale 1ns/1ps
// scanline emulator
// works out a per-line darkening strength from the relative line position
// and the selected profile, lets bright pixels bloom through, and scales
// each active pixel; ten cycle fixed latency, no stall path

module scanline_emu (
  input  logic                         VCLK_i,
  input  logic                         nVRST_i,
  input  logic                         hsync_i,
  input  logic                         vsync_i,
  input  logic                         de_i,
  input  logic [sl_pkg::VDATA_W-1:0]   vdata_i,
  input  logic                         sl_en_i,
  input  logic                         sl_thickness_i,
  input  sl_pkg::sl_profile_e          sl_profile_i,
  input  logic [7:0]                   sl_rel_pos_i,
  input  logic [7:0]                   sl_strength_i,
  input  logic [4:0]                   sl_bloom_i,
  output logic                         hsync_o,
  output logic                         vsync_o,
  output logic                         de_o,
  output logic [sl_pkg::VDATA_W-1:0]   vdata_o
);

  // input channels
  logic [sl_pkg::COLOR_W-1:0] red_w, green_w, blue_w;

  // delay lines, stages 0..8
  logic [sl_pkg::PROC_STAGES-2:0] hsync_dly, vsync_dly, de_dly;
  logic [sl_pkg::COLOR_W-1:0] red_dly   [0:sl_pkg::PROC_STAGES-2];
  logic [sl_pkg::COLOR_W-1:0] green_dly [0:sl_pkg::PROC_STAGES-2];
  logic [sl_pkg::COLOR_W-1:0] blue_dly  [0:sl_pkg::PROC_STAGES-2];

  // luma
  logic [sl_pkg::COLOR_W:0] rpb_q;
  logic [sl_pkg::Y_W-1:0]   y_q [1:2];

  // strength path
  logic                              flat_w;
  logic [7:0]                        sl_offset_w;   // thick line start, luma adaptive
  logic [sl_pkg::PROC_STAGES-2:2]    draw_sl;
  logic [3:2]                        max_str;
  logic [7:0]                        str_q [0:5];
  logic [15:0]                       str_scaled_w;

  // bloom path
  logic [sl_pkg::Y_W+4:0] yref_pre_full_w;
  logic [sl_pkg::Y_W+7:0] yref_full_w;
  logic [sl_pkg::Y_W-1:0] yref_pre_q [3:4];
  logic [sl_pkg::Y_W-1:0] yref_q;
  logic [7:0]             bloom_rval_q, bloomed_str_q;

  // scaled pixel
  logic [2*sl_pkg::COLOR_W-1:0] red_sl_w, green_sl_w, blue_sl_w;
  logic [sl_pkg::COLOR_W-1:0]   red_sl_q, green_sl_q, blue_sl_q;

  assign red_w   = vdata_i[3*sl_pkg::COLOR_W-1:2*sl_pkg::COLOR_W];
  assign green_w = vdata_i[2*sl_pkg::COLOR_W-1:sl_pkg::COLOR_W];
  assign blue_w  = vdata_i[sl_pkg::COLOR_W-1:0];

  ////////////////////////////////////////
  // sync and pixel delay
  ////////////////////////////////////////

  always_ff @(posedge VCLK_i or negedge nVRST_i) begin
    if (!nVRST_i) begin
      hsync_dly <= '0;
      vsync_dly <= '0;
      de_dly    <= '0;
      for (int i = 0; i < sl_pkg::PROC_STAGES-1; i++) begin
        red_dly[i]   <= '0;
        green_dly[i] <= '0;
        blue_dly[i]  <= '0;
      end
    end else begin
      hsync_dly <= {hsync_dly[sl_pkg::PROC_STAGES-3:0], hsync_i};
      vsync_dly <= {vsync_dly[sl_pkg::PROC_STAGES-3:0], vsync_i};
      de_dly    <= {de_dly[sl_pkg::PROC_STAGES-3:0], de_i};
      red_dly[0]   <= red_w;
      green_dly[0] <= green_w;
      blue_dly[0]  <= blue_w;
      for (int i = 1; i < sl_pkg::PROC_STAGES-1; i++) begin
        red_dly[i]   <= red_dly[i-1];
        green_dly[i] <= green_dly[i-1];
        blue_dly[i]  <= blue_dly[i-1];
      end
    end
  end

  ////////////////////////////////////////
  // luma estimate, g + (r+b)/2
  ////////////////////////////////////////

  always_ff @(posedge VCLK_i) begin
    rpb_q  <= {1'b0, red_w} + {1'b0, blue_w};                              // stage 0
    y_q[1] <= {1'b0, green_dly[0]} + {1'b0, rpb_q[sl_pkg::COLOR_W:1]};     // stage 1
    y_q[2] <= y_q[1];                                                      // stage 2
  end

  ////////////////////////////////////////
  // strength and draw decision
  ////////////////////////////////////////

  assign flat_w       = (sl_profile_i == sl_pkg::SL_FLAT);
  assign str_scaled_w = str_q[3] * sl_strength_i;

  // 0 for black up to 0.25 for full luma
  assign sl_offset_w = {2'b00, y_q[1][sl_pkg::Y_W-1:sl_pkg::Y_W-6]}
                     + 8'(y_q[1][sl_pkg::Y_W-7]);

  // draw and full strength flags, one bit per stage
  always_ff @(posedge VCLK_i or negedge nVRST_i) begin
    if (!nVRST_i) begin
      draw_sl <= '0;
      max_str <= '0;
    end else begin
      if (sl_thickness_i) begin
        draw_sl[2] <= str_q[1] > sl_offset_w;
        max_str[2] <= str_q[1] >= sl_offset_w + sl_pkg::SL_WIN_W;
      end else begin
        draw_sl[2] <= str_q[1] > sl_pkg::SL_POS_QUARTER;
        max_str[2] <= str_q[1] >= sl_pkg::SL_POS_QUARTER + sl_pkg::SL_WIN_W;
      end
      // flat top: upper half of the ramp and beyond is drawn at full strength
      if (flat_w) begin
        draw_sl[3] <= draw_sl[2] & (str_q[2][5] | max_str[2]);
        max_str[3] <= str_q[2][5] | max_str[2];
      end else begin
        draw_sl[3] <= draw_sl[2];
        max_str[3] <= max_str[2];
      end
      draw_sl[4] <= sl_en_i & draw_sl[3];
      for (int i = 5; i < sl_pkg::PROC_STAGES-1; i++)
        draw_sl[i] <= draw_sl[i-1];
    end
  end

  always_ff @(posedge VCLK_i) begin
    // fold into 0..0.5, 8'h00 to 8'h80
    str_q[0] <= (sl_rel_pos_i > sl_pkg::SL_POS_HALF) ? 8'(~sl_rel_pos_i + 8'd1)
                                                     : sl_rel_pos_i;
    str_q[1] <= str_q[0];                          // wait for luma
    str_q[2] <= sl_thickness_i ? str_q[1] - sl_offset_w
                               : str_q[1] - sl_pkg::SL_POS_QUARTER; // ramp position
    case (sl_profile_i)
      sl_pkg::SL_HANN:  str_q[3] <= sl_pkg::hann_shape(str_q[2][5:0]);
      sl_pkg::SL_GAUSS: str_q[3] <= sl_pkg::gauss_shape(str_q[2][5:0]);
      default:          str_q[3] <= {str_q[2][5:0], str_q[2][5:4]}; // linear ramp
    endcase
    str_q[4] <= max_str[3] ? sl_strength_i : str_scaled_w[15:8];
    str_q[5] <= str_q[4];
  end

  ////////////////////////////////////////
  // bloom reference and factor
  ////////////////////////////////////////

  assign yref_pre_full_w = y_q[2] * sl_bloom_i;
  assign yref_full_w     = yref_pre_q[4] * str_q[4];

  always_ff @(posedge VCLK_i) begin
    yref_pre_q[3] <= yref_pre_full_w[sl_pkg::Y_W+4:5];             // stage 3, luma*bloom/32
    yref_pre_q[4] <= yref_pre_q[3];                                // stage 4
    yref_q        <= yref_full_w[sl_pkg::Y_W+7:8];                 // stage 5, times strength
    // bright pixels eat into the darkening, never below 0
    bloom_rval_q  <= ({1'b0, str_q[5]} < yref_q) ? 8'd0
                                                 : str_q[5] - yref_q[7:0]; // stage 6
    bloomed_str_q <= 8'hff - bloom_rval_q;                         // stage 7
  end

  ////////////////////////////////////////
  // pixel scaling and output
  ////////////////////////////////////////

  assign red_sl_w   = red_dly[sl_pkg::PROC_STAGES-3]   * bloomed_str_q;
  assign green_sl_w = green_dly[sl_pkg::PROC_STAGES-3] * bloomed_str_q;
  assign blue_sl_w  = blue_dly[sl_pkg::PROC_STAGES-3]  * bloomed_str_q;

  always_ff @(posedge VCLK_i) begin
    red_sl_q   <= red_sl_w[2*sl_pkg::COLOR_W-1:sl_pkg::COLOR_W];   // stage 8
    green_sl_q <= green_sl_w[2*sl_pkg::COLOR_W-1:sl_pkg::COLOR_W];
    blue_sl_q  <= blue_sl_w[2*sl_pkg::COLOR_W-1:sl_pkg::COLOR_W];
  end

  always_ff @(posedge VCLK_i or negedge nVRST_i) begin
    if (!nVRST_i) begin
      hsync_o <= 1'b0;
      vsync_o <= 1'b0;
      de_o    <= 1'b0;
      vdata_o <= '0;
    end else begin
      hsync_o <= hsync_dly[sl_pkg::PROC_STAGES-2];
      vsync_o <= vsync_dly[sl_pkg::PROC_STAGES-2];
      de_o    <= de_dly[sl_pkg::PROC_STAGES-2];
      if (de_dly[sl_pkg::PROC_STAGES-2] && draw_sl[sl_pkg::PROC_STAGES-2])
        vdata_o <= {red_sl_q, green_sl_q, blue_sl_q};
      else
        vdata_o <= {red_dly[sl_pkg::PROC_STAGES-2],
                    green_dly[sl_pkg::PROC_STAGES-2],
                    blue_dly[sl_pkg::PROC_STAGES-2]};   // blanking or no scanline
    end
  end

endmodule

// File: design/scanline_top.sv
`timescale 1ns/1ps
// scanline subsystem top
// configuration registers, line phase tracker and emulator,
// video passes with a fixed ten cycle latency

module scanline_top (
  input  logic                       VCLK_i,
  input  logic                       nVRST_i,
  input  logic                       hsync_i,
  input  logic                       vsync_i,
  input  logic                       de_i,
  input  logic [sl_pkg::VDATA_W-1:0] vdata_i,
  input  logic                       cfg_valid_i,
  input  sl_pkg::sl_reg_e            cfg_addr_i,
  input  logic [7:0]                 cfg_wdata_i,
  output logic                       cfg_ready_o,
  output logic                       hsync_o,
  output logic                       vsync_o,
  output logic                       de_o,
  output logic [sl_pkg::VDATA_W-1:0] vdata_o
);

  // live configuration
  logic                sl_en;
  logic                sl_thickness;
  sl_pkg::sl_profile_e sl_profile;
  logic [7:0]          sl_strength;
  logic [4:0]          sl_bloom;
  logic [2:0]          sl_mult;
  logic [7:0]          sl_rel_pos; // one cycle behind the syncs that made it

  sl_cfg_regs cfg_regs0 (
    .VCLK_i        (VCLK_i),
    .nVRST_i       (nVRST_i),
    .vsync_i       (vsync_i),
    .cfg_valid_i   (cfg_valid_i),
    .cfg_addr_i    (cfg_addr_i),
    .cfg_wdata_i   (cfg_wdata_i),
    .cfg_ready_o   (cfg_ready_o),
    .sl_en_o       (sl_en),
    .sl_thickness_o(sl_thickness),
    .sl_profile_o  (sl_profile),
    .sl_strength_o (sl_strength),
    .sl_bloom_o    (sl_bloom),
    .sl_mult_o     (sl_mult)
  );

  sl_line_phase line_phase0 (
    .VCLK_i      (VCLK_i),
    .nVRST_i     (nVRST_i),
    .hsync_i     (hsync_i),
    .vsync_i     (vsync_i),
    .sl_mult_i   (sl_mult),
    .sl_rel_pos_o(sl_rel_pos)
  );

  scanline_emu scanline_emu0 (
    .VCLK_i        (VCLK_i),
    .nVRST_i       (nVRST_i),
    .hsync_i       (hsync_i),
    .vsync_i       (vsync_i),
    .de_i          (de_i),
    .vdata_i       (vdata_i),
    .sl_en_i       (sl_en),
    .sl_thickness_i(sl_thickness),
    .sl_profile_i  (sl_profile),
    .sl_rel_pos_i  (sl_rel_pos),
    .sl_strength_i (sl_strength),
    .sl_bloom_i    (sl_bloom),
    .hsync_o       (hsync_o),
    .vsync_o       (vsync_o),
    .de_o          (de_o),
    .vdata_o       (vdata_o)
  );

endmodule

// File: dv/sl_checker.sv
`timescale 1ns/1ps
// scanline checker
// mirrors the config registers and the sub-line counter from the DUT inputs,
// predicts every output ten cycles ahead and compares it with the DUT

module sl_checker (
  input  logic                       VCLK_i,
  input  logic                       nVRST_i,
  input  logic                       hsync_i,
  input  logic                       vsync_i,
  input  logic                       de_i,
  input  logic [sl_pkg::VDATA_W-1:0] vdata_i,
  input  logic                       cfg_valid_i,
  input  logic                       cfg_ready_i,
  input  sl_pkg::sl_reg_e            cfg_addr_i,
  input  logic [7:0]                 cfg_wdata_i,
  input  logic                       dut_hsync_i,
  input  logic                       dut_vsync_i,
  input  logic                       dut_de_i,
  input  logic [sl_pkg::VDATA_W-1:0] dut_vdata_i,
  output int                         err_cnt_o,
  output int                         chk_cnt_o
);

  logic [7:0]  pend [0:3];    // ctrl, strength, bloom, mult
  logic [7:0]  live [0:3];    // frame stable copy
  logic [26:0] exp_q [0:sl_pkg::PROC_STAGES-1];   // {hsync, vsync, de, pixel}, one per cycle
  logic [23:0] floor_q [0:sl_pkg::PROC_STAGES-1]; // same pixel without bloom
  logic        vs_q, hs_q;
  int          k;             // sub-line count

  function automatic logic [7:0] scale(input logic [7:0] c, input int fac);
    return 8'((c * fac) >> 8);
  endfunction

  // 255 minus what is left of the strength after the luma reference
  function automatic int bloom_factor(input logic [23:0] px, input int str, input int bloom);
    int y;
    int yref;
    y    = px[15:8] + ((px[23:16] + px[7:0]) >> 1);
    yref = (((y * bloom) >> 5) * str) >> 8;
    return (str < yref) ? 255 : 255 - (str - yref);
  endfunction

  // strength of the current line, -1 where no scanline is drawn
  // model covers the rect and flat profiles at normal thickness
  function automatic int line_strength(input int kk);
    int   pos;
    int   fold;
    int   ramp;
    logic flat;
    pos  = (kk * 256) / live[3];
    fold = (pos > 128) ? 256 - pos : pos;   // mirror around half a line
    ramp = (fold - 64) % 64;
    flat = (live[0][3:2] == sl_pkg::SL_FLAT);
    if (!live[0][0] || fold <= 64 || (flat && fold < 128 && ramp < 32))
      return -1;
    if (fold >= 128 || flat)
      return live[1];
    return ((ramp * 4 + ramp / 16) * live[1]) >> 8; // linear ramp
  endfunction

  ////////////////////////////////////////
  // compare, then predict
  ////////////////////////////////////////

  always @(negedge VCLK_i) begin : check_proc
    logic [23:0] want_px;
    logic [23:0] floor_px;
    logic [26:0] old_exp;
    logic [23:0] old_floor;
    int          str;
    int          fac;
    if (!nVRST_i) begin
      pend[0] = {4'd0, sl_pkg::SL_RECT, 2'b00};   // disabled
      pend[1] = 8'd0;
      pend[2] = 8'd0;
      pend[3] = 8'd2;
      live    = pend;
      for (int i = 0; i < sl_pkg::PROC_STAGES; i++) begin
        exp_q[i]   = '0;
        floor_q[i] = '0;
      end
      k = 0;
      vs_q = 1'b0;
      hs_q = 1'b0;
      err_cnt_o = 0;
      chk_cnt_o = 0;
    end else begin
      old_exp   = exp_q[sl_pkg::PROC_STAGES-1];
      old_floor = floor_q[sl_pkg::PROC_STAGES-1];
      chk_cnt_o = chk_cnt_o + 1;
      if (cfg_ready_i !== vsync_i) begin
        err_cnt_o = err_cnt_o + 1;
        $display("CHECK FAILED t=%0t: cfg_ready exp %b got %b", $time, vsync_i, cfg_ready_i);
      end
      if ({dut_hsync_i, dut_vsync_i, dut_de_i} !== old_exp[26:24]) begin
        err_cnt_o = err_cnt_o + 1;
        $display("CHECK FAILED t=%0t: hsync/vsync/de exp %b got %b", $time,
                 old_exp[26:24], {dut_hsync_i, dut_vsync_i, dut_de_i});
      end
      if (dut_vdata_i !== old_exp[23:0]) begin
        err_cnt_o = err_cnt_o + 1;
        $display("CHECK FAILED t=%0t: vdata exp %h got %h", $time, old_exp[23:0], dut_vdata_i);
      end
      if (dut_vdata_i[23:16] < old_floor[23:16] || dut_vdata_i[15:8] < old_floor[15:8] ||
          dut_vdata_i[7:0] < old_floor[7:0]) begin
        err_cnt_o = err_cnt_o + 1;
        $display("CHECK FAILED t=%0t: vdata %h darker than without bloom %h", $time,
                 dut_vdata_i, old_floor);
      end
      for (int i = sl_pkg::PROC_STAGES-1; i > 0; i--) begin
        exp_q[i]   = exp_q[i-1];
        floor_q[i] = floor_q[i-1];
      end
      // host write lands at the coming edge
      if (cfg_valid_i && cfg_ready_i) begin
        if (cfg_addr_i == sl_pkg::SL_REG_MULT)
          pend[3] = (cfg_wdata_i < 8'd2) ? 8'd2 : (cfg_wdata_i > 8'd4) ? 8'd4 : cfg_wdata_i;
        else
          pend[cfg_addr_i] = cfg_wdata_i;
      end
      if (vs_q && !vsync_i)
        live = pend;                      // end of blanking
      if (vsync_i && !vs_q)
        k = 0;
      else if (hsync_i && !hs_q)
        k = (k + 1 >= live[3]) ? 0 : k + 1;
      vs_q = vsync_i;
      hs_q = hsync_i;
      str      = line_strength(k);
      want_px  = vdata_i;
      floor_px = vdata_i;
      if (de_i && str >= 0) begin
        fac      = bloom_factor(vdata_i, str, live[2][4:0]);
        want_px  = {scale(vdata_i[23:16], fac), scale(vdata_i[15:8], fac),
                    scale(vdata_i[7:0], fac)};
        floor_px = {scale(vdata_i[23:16], 255 - str), scale(vdata_i[15:8], 255 - str),
                    scale(vdata_i[7:0], 255 - str)};
      end
      exp_q[0]   = {hsync_i, vsync_i, de_i, want_px};
      floor_q[0] = floor_px;
    end
  end

endmodule

// File: dv/tb_scanline.sv
`timescale 1ns/1ps
// scanline subsystem testbench
// one table row per configuration, two frames of video per row,
// host writes go out during active video and complete in blanking

module tb_scanline;

  localparam int N_ROWS    = 8;
  localparam int LINE_CYC  = 28;                        // 4 sync, 4 porch, 16 active, 4 porch
  localparam int VBLANK    = 24;
  localparam int FRAME_CYC = 4 + 8 * LINE_CYC + VBLANK; // top porch, 8 lines, blanking
  localparam int WD_CYC    = N_ROWS * FRAME_CYC * 2 + 500;

  typedef struct packed {
    logic [7:0]  ctrl;
    logic [7:0]  strength;
    logic [7:0]  bloom;
    logic [7:0]  mult;
    logic [31:0] seed;   // mixed into the pixel generator
  } row_t;

  logic                       vclk = 1'b0;
  logic                       nvrst = 1'b0;
  logic                       hsync, vsync, de;
  logic [sl_pkg::VDATA_W-1:0] vdata;
  logic                       cfg_valid;
  sl_pkg::sl_reg_e            cfg_addr;
  logic [7:0]                 cfg_wdata;
  logic                       cfg_ready;
  logic                       hsync_out, vsync_out, de_out;
  logic [sl_pkg::VDATA_W-1:0] vdata_out;
  int                         err_cnt, chk_cnt;
  logic [31:0]                lcg_q;
  row_t                       stim [0:N_ROWS-1];

  scanline_top dut0 (
    .VCLK_i(vclk), .nVRST_i(nvrst),
    .hsync_i(hsync), .vsync_i(vsync), .de_i(de), .vdata_i(vdata),
    .cfg_valid_i(cfg_valid), .cfg_addr_i(cfg_addr), .cfg_wdata_i(cfg_wdata),
    .cfg_ready_o(cfg_ready),
    .hsync_o(hsync_out), .vsync_o(vsync_out), .de_o(de_out), .vdata_o(vdata_out)
  );

  sl_checker chk0 (
    .VCLK_i(vclk), .nVRST_i(nvrst),
    .hsync_i(hsync), .vsync_i(vsync), .de_i(de), .vdata_i(vdata),
    .cfg_valid_i(cfg_valid), .cfg_ready_i(cfg_ready),
    .cfg_addr_i(cfg_addr), .cfg_wdata_i(cfg_wdata),
    .dut_hsync_i(hsync_out), .dut_vsync_i(vsync_out), .dut_de_i(de_out),
    .dut_vdata_i(vdata_out),
    .err_cnt_o(err_cnt), .chk_cnt_o(chk_cnt)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [7:0] ctrl_byte(input logic en, input sl_pkg::sl_profile_e prof);
    return {4'd0, prof, 1'b0, en};   // normal thickness
  endfunction

  task automatic drive_cycle(input logic h, input logic v, input logic d, input int x);
    @(posedge vclk);
    lcg_q = lcg_next(lcg_q);
    hsync <= h;
    vsync <= v;
    de    <= d;
    vdata <= (d && x % 4 == 3) ? 24'hffffff : lcg_q[31:8]; // every fourth pixel white
  endtask

  task automatic send_frame();
    repeat (4) drive_cycle(1'b0, 1'b0, 1'b0, 0);
    for (int ln = 0; ln < 8; ln++)
      for (int c = 0; c < LINE_CYC; c++)
        drive_cycle(c < 4, 1'b0, c >= 8 && c < 24, c - 8);
    repeat (VBLANK) drive_cycle(1'b0, 1'b1, 1'b0, 0);
  endtask

  task automatic write_reg(input sl_pkg::sl_reg_e addr, input logic [7:0] data);
    cfg_valid <= 1'b1;
    cfg_addr  <= addr;
    cfg_wdata <= data;
    @(posedge vclk);
    while (!cfg_ready) @(posedge vclk);   // held until vertical blanking
  endtask

  task automatic write_row(input row_t r);
    write_reg(sl_pkg::SL_REG_CTRL, r.ctrl);
    write_reg(sl_pkg::SL_REG_STRENGTH, r.strength);
    write_reg(sl_pkg::SL_REG_BLOOM, r.bloom);
    write_reg(sl_pkg::SL_REG_MULT, r.mult);
    cfg_valid <= 1'b0;
  endtask

  initial begin
    forever #50 vclk = ~vclk;
  end

  initial begin : watchdog
    repeat (WD_CYC) @(posedge vclk);
    $display("timeout: test did not finish within %0d clock cycles", WD_CYC);
    $display("Testbench failed");
    $finish;
  end

  initial begin
    stim[0] = '{ctrl_byte(1'b0, sl_pkg::SL_RECT), 8'd200, 8'd0, 8'd2, 32'h0}; // off
    stim[1] = '{ctrl_byte(1'b1, sl_pkg::SL_RECT), 8'd160, 8'd0, 8'd2, 32'h1};
    stim[2] = '{ctrl_byte(1'b1, sl_pkg::SL_RECT), 8'd96, 8'd0, 8'd2, 32'h2};  // strength change
    stim[3] = '{ctrl_byte(1'b1, sl_pkg::SL_FLAT), 8'd255, 8'd0, 8'd4, 32'h3};
    stim[4] = '{ctrl_byte(1'b1, sl_pkg::SL_RECT), 8'd200, 8'd31, 8'd2, 32'h4}; // full bloom
    stim[5] = '{ctrl_byte(1'b1, sl_pkg::SL_FLAT), 8'd128, 8'd16, 8'd9, 32'h5}; // M clamps to 4
    stim[6] = '{ctrl_byte(1'b1, sl_pkg::SL_RECT), 8'd255, 8'd0, 8'd3, 32'h6};  // ramp lines
    stim[7] = '{ctrl_byte(1'b1, sl_pkg::SL_RECT), 8'd0, 8'd0, 8'd1, 32'h7};    // M clamps to 2
    hsync     = 1'b0;
    vsync     = 1'b0;
    de        = 1'b0;
    vdata     = '0;
    cfg_valid = 1'b0;
    cfg_addr  = sl_pkg::SL_REG_CTRL;
    cfg_wdata = 8'd0;
    lcg_q     = 32'h74385a6e;
    repeat (5) @(posedge vclk);
    nvrst <= 1'b1;
    for (int r = 0; r < N_ROWS; r++) begin
      lcg_q = 32'h74385a6e ^ stim[r].seed;
      fork
        write_row(stim[r]);
        begin
          send_frame();   // still on the old settings
          send_frame();
        end
      join
    end
    repeat (20) drive_cycle(1'b0, 1'b0, 1'b0, 0); // drain the pipeline
    $display("closing report: %0d errors in %0d checked cycles", err_cnt, chk_cnt);
    if (err_cnt == 0 && chk_cnt > 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

// File: files.f
design/sl_pkg.sv
design/sl_cfg_regs.sv
design/sl_line_phase.sv
design/scanline_emu.sv
design/scanline_top.sv
dv/sl_checker.sv
dv/tb_scanline.sv

// File: Makefile
# verilator flow for the scanline subsystem testbench

LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module tb_scanline -Mdir obj_dir -f files.f

run: compile
	./obj_dir/Vtb_scanline | tee $(LOG)
	@if grep -q "Testbench failed" $(LOG); then echo "FAIL: see $(LOG)"; exit 1; fi
	@grep -q "Testbench passed" $(LOG) || { echo "FAIL: no result in $(LOG)"; exit 1; }
	@echo "PASS"

clean:
	rm -rf obj_dir $(LOG)
